// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing -Wno-fatal --top-module tb_hd44780_controller -f hd44780_controller.f
	./obj_dir/Vtb_hd44780_controller | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hd44780_controller.f
lcd_pkg.sv
lcd_ifs.sv
lcd_byte_capture.sv
lcd_nybble_sequencer.sv
lcd_bus_driver.sv
hd44780_controller.sv
tb_hd44780_controller.sv

// File: hd44780_controller.sv
// top level of the HD44780 4-bit write path
// byte capture, nybble sequencer and bus driver joined by two channels

`timescale 1ns/1ns

module hd44780_controller (
    input  logic                           CLK_I,
    input  logic                           RST_I,
    input  logic                           i_stb,
    input  logic                           i_rs,
    input  logic [lcd_pkg::LCD_BYTE_W-1:0] i_lcd_data,
    output logic                           o_busy,
    output logic                           o_rs,
    output logic [lcd_pkg::LCD_NYB_W-1:0]  o_lcd_data,
    output logic                           o_e
);

    // captured byte on its way to the sequencer
    byte_chan_if   byte_chan ();
    // single nybble on its way to the pins
    nybble_chan_if nyb_chan ();

    // **********************************************************************
    // input side
    // **********************************************************************
    lcd_byte_capture capture_i (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .i_stb   (i_stb),
        .i_rs    (i_rs),
        .i_data  (i_lcd_data),
        .o_busy  (o_busy),
        .byte_tx (byte_chan)
    );

    // upper nybble goes out first, then the lower one
    lcd_nybble_sequencer sequencer_i (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .byte_rx (byte_chan),
        .nyb_tx  (nyb_chan)
    );

    // **********************************************************************
    // output side
    // **********************************************************************
    lcd_bus_driver bus_driver_i (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .nyb_rx     (nyb_chan),
        .o_rs       (o_rs),
        .o_lcd_data (o_lcd_data),
        .o_e        (o_e)
    );

endmodule

// File: lcd_bus_driver.sv
// LCD pin side, one nybble per start pulse
// steps through setup, enable high, hold and pad with a down counter

`timescale 1ns/1ns

module lcd_bus_driver (
    input  logic                          CLK_I,
    input  logic                          RST_I,
    nybble_chan_if.sink                   nyb_rx,
    output logic                          o_rs,
    output logic [lcd_pkg::LCD_NYB_W-1:0] o_lcd_data,
    output logic                          o_e
);

    lcd_pkg::bus_phase_e phase;

    // cycles left in the current phase, minus one
    lcd_pkg::tick_t tick_cnt;

    logic phase_done;

    assign phase_done  = (tick_cnt == '0);

    // every phase except idle belongs to the transfer
    assign nyb_rx.busy = (phase != lcd_pkg::PH_IDLE);

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            phase      <= lcd_pkg::PH_IDLE;
            tick_cnt   <= '0;
            o_rs       <= 1'b0;
            o_lcd_data <= '0;
            o_e        <= 1'b0;
        end else begin
            unique case (phase)
                lcd_pkg::PH_IDLE: begin
                    // pins take the new nybble on the cycle after start
                    if (nyb_rx.start) begin
                        o_rs       <= nyb_rx.rs;
                        o_lcd_data <= nyb_rx.nybble;
                        tick_cnt   <= lcd_pkg::tick_t'(lcd_pkg::T_AS_TICKS - 1);
                        phase      <= lcd_pkg::PH_SETUP;
                    end
                end
                lcd_pkg::PH_SETUP: begin
                    if (phase_done) begin
                        // enable goes up together with the phase change
                        o_e      <= 1'b1;
                        tick_cnt <= lcd_pkg::tick_t'(lcd_pkg::T_PWEH_TICKS - 1);
                        phase    <= lcd_pkg::PH_E_HIGH;
                    end else begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end
                end
                lcd_pkg::PH_E_HIGH: begin
                    if (phase_done) begin
                        // the falling edge is where the LCD latches the nybble
                        o_e      <= 1'b0;
                        tick_cnt <= lcd_pkg::tick_t'(lcd_pkg::T_AH_TICKS - 1);
                        phase    <= lcd_pkg::PH_HOLD;
                    end else begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end
                end
                lcd_pkg::PH_HOLD: begin
                    if (phase_done) begin
                        tick_cnt <= lcd_pkg::tick_t'(lcd_pkg::T_PAD_TICKS - 1);
                        phase    <= lcd_pkg::PH_PAD;
                    end else begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end
                end
                lcd_pkg::PH_PAD: begin
                    // pins keep the last nybble, only the cycle time is filled
                    if (phase_done) begin
                        phase <= lcd_pkg::PH_IDLE;
                    end else begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end
                end
                default: begin
                    o_e   <= 1'b0;
                    phase <= lcd_pkg::PH_IDLE;
                end
            endcase
        end
    end

endmodule

// File: lcd_byte_capture.sv
// host side of the controller
// takes the strobe, shadows rs and the data byte, and drives the busy flag

`timescale 1ns/1ns

module lcd_byte_capture (
    input  logic                           CLK_I,
    input  logic                           RST_I,
    input  logic                           i_stb,
    input  logic                           i_rs,
    input  logic [lcd_pkg::LCD_BYTE_W-1:0] i_data,
    output logic                           o_busy,
    byte_chan_if.source                    byte_tx
);

    lcd_pkg::capture_state_e state;

    // shadow copies, so the host may change its lines once the byte is taken
    logic                           rs_q;
    logic [lcd_pkg::LCD_BYTE_W-1:0] data_q;

    // busy while a byte is in flight here or anywhere further down
    assign o_busy = (state != lcd_pkg::CAP_IDLE) || !byte_tx.ready;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state <= lcd_pkg::CAP_IDLE;
        end else begin
            unique case (state)
                lcd_pkg::CAP_IDLE: begin
                    // a strobe only counts while nothing is pending
                    if (i_stb && !o_busy) begin
                        state <= lcd_pkg::CAP_WAIT_REL;
                    end
                end
                lcd_pkg::CAP_WAIT_REL: begin
                    // the byte is taken once the host lets go of the strobe
                    if (!i_stb) begin
                        state <= lcd_pkg::CAP_HANDOFF;
                    end
                end
                lcd_pkg::CAP_HANDOFF: begin
                    if (byte_tx.ready) begin
                        state <= lcd_pkg::CAP_IDLE;
                    end
                end
                default: state <= lcd_pkg::CAP_IDLE;
            endcase
        end
    end

    // rs is sampled on the accept edge and data on the release edge
    always_ff @(posedge CLK_I) begin
        if (state == lcd_pkg::CAP_IDLE && i_stb && !o_busy) begin
            rs_q <= i_rs;
        end
        if (state == lcd_pkg::CAP_WAIT_REL && !i_stb) begin
            data_q <= i_data;
        end
    end

    assign byte_tx.valid = (state == lcd_pkg::CAP_HANDOFF);
    assign byte_tx.rs    = rs_q;
    assign byte_tx.data  = data_q;

endmodule

// File: lcd_ifs.sv
// internal channels of the LCD write path
// byte channel from capture to sequencer, nybble channel from sequencer to bus driver

`timescale 1ns/1ns

// one captured byte waiting for the sequencer
// a byte moves on a cycle where valid and ready are both high
interface byte_chan_if;
    logic                        valid;
    logic                        rs;
    logic [lcd_pkg::LCD_BYTE_W-1:0] data;
    logic                        ready;

    modport source (output valid, output rs, output data, input ready);
    modport sink   (input valid, input rs, input data, output ready);
endinterface

// one nybble for the bus driver
// start is a single-cycle pulse and busy answers from the next cycle on
interface nybble_chan_if;
    logic                       start;
    logic                       rs;
    logic [lcd_pkg::LCD_NYB_W-1:0] nybble;
    logic                       busy;

    modport source (output start, output rs, output nybble, input busy);
    modport sink   (input start, input rs, input nybble, output busy);
endinterface

// File: lcd_nybble_sequencer.sv
// splits one byte into two nybble transfers, upper nybble first
// waits for the bus driver to finish each transfer before the next

`timescale 1ns/1ns

module lcd_nybble_sequencer (
    input  logic          CLK_I,
    input  logic          RST_I,
    byte_chan_if.sink     byte_rx,
    nybble_chan_if.source nyb_tx
);

    lcd_pkg::seq_state_e state;

    // byte and rs held for both halves
    logic                           rs_q;
    logic [lcd_pkg::LCD_BYTE_W-1:0] byte_q;

    // set once the driver has raised busy for the current nybble
    logic busy_seen;

    logic take_byte;

    // a new byte is welcome only with nothing in progress here or in the driver
    assign byte_rx.ready = (state == lcd_pkg::SEQ_IDLE) && !nyb_tx.busy;
    assign take_byte     = byte_rx.valid && byte_rx.ready;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state     <= lcd_pkg::SEQ_IDLE;
            busy_seen <= 1'b0;
        end else begin
            unique case (state)
                lcd_pkg::SEQ_IDLE: begin
                    busy_seen <= 1'b0;
                    if (take_byte) begin
                        state <= lcd_pkg::SEQ_SEND_UPPER;
                    end
                end
                lcd_pkg::SEQ_SEND_UPPER: begin
                    state <= lcd_pkg::SEQ_WAIT_UPPER;
                end
                lcd_pkg::SEQ_WAIT_UPPER: begin
                    // the lower half may only go once busy has been up and is down again
                    if (nyb_tx.busy) begin
                        busy_seen <= 1'b1;
                    end else if (busy_seen) begin
                        busy_seen <= 1'b0;
                        state     <= lcd_pkg::SEQ_SEND_LOWER;
                    end
                end
                lcd_pkg::SEQ_SEND_LOWER: begin
                    state <= lcd_pkg::SEQ_WAIT_LOWER;
                end
                lcd_pkg::SEQ_WAIT_LOWER: begin
                    if (nyb_tx.busy) begin
                        busy_seen <= 1'b1;
                    end else if (busy_seen) begin
                        busy_seen <= 1'b0;
                        state     <= lcd_pkg::SEQ_IDLE;
                    end
                end
                default: state <= lcd_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK_I) begin
        if (take_byte) begin
            rs_q   <= byte_rx.rs;
            byte_q <= byte_rx.data;
        end
    end

    // **********************************************************************
    // nybble channel, decoded straight from the state
    // **********************************************************************

    // start lasts exactly one cycle because each send state lasts one cycle
    assign nyb_tx.start = (state == lcd_pkg::SEQ_SEND_UPPER) ||
                          (state == lcd_pkg::SEQ_SEND_LOWER);
    assign nyb_tx.rs    = rs_q;
    assign nyb_tx.nybble = (state == lcd_pkg::SEQ_SEND_LOWER) ?
                           byte_q[lcd_pkg::LCD_NYB_W-1:0] :
                           byte_q[lcd_pkg::LCD_BYTE_W-1 -: lcd_pkg::LCD_NYB_W];

endmodule

// File: lcd_pkg.sv
// shared constants and state types for the HD44780 4-bit write path
// timing counts assume a 48 MHz clock

package lcd_pkg;

    // widths of the host byte and of the LCD data bus in 4-bit mode
    localparam int LCD_BYTE_W = 8;
    localparam int LCD_NYB_W  = 4;

    // **********************************************************************
    // nybble transfer timing, in clock cycles
    // **********************************************************************

    // rs and data valid before enable rises (tAS is 40 ns minimum)
    localparam int T_AS_TICKS   = 3;
    // enable high width (tPWEH is 450 ns minimum)
    localparam int T_PWEH_TICKS = 22;
    // rs and data hold after enable falls
    localparam int T_AH_TICKS   = 2;
    // idle fill so that the whole transfer covers the 1 us enable cycle time
    localparam int T_PAD_TICKS  = 21;

    // busy length of one nybble, every phase added up
    localparam int NYB_XFER_TICKS = T_AS_TICKS + T_PWEH_TICKS + T_AH_TICKS + T_PAD_TICKS;

    // the driver counter has to hold the longest phase
    localparam int MAX_PHASE_TICKS =
        (T_PWEH_TICKS > T_PAD_TICKS) ? T_PWEH_TICKS : T_PAD_TICKS;
    localparam int TICK_W = $clog2(MAX_PHASE_TICKS + 1);

    typedef logic [TICK_W-1:0] tick_t;

    // **********************************************************************
    // state encodings
    // **********************************************************************

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_REL,
        CAP_HANDOFF
    } capture_state_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_SEND_UPPER,
        SEQ_WAIT_UPPER,
        SEQ_SEND_LOWER,
        SEQ_WAIT_LOWER
    } seq_state_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_SETUP,
        PH_E_HIGH,
        PH_HOLD,
        PH_PAD
    } bus_phase_e;

endpackage

// File: tb_hd44780_controller.sv
// testbench for the HD44780 4-bit write path
// random bytes from a fixed seed, checked against a queue model of the nybbles

`timescale 1ns/1ns

module tb_hd44780_controller;

    // 4 directed bytes and 40 random ones, each given its longest path
    localparam int CYCLE_LIMIT = 44 * (2 * lcd_pkg::NYB_XFER_TICKS + 16) + 200;

    logic                           CLK_I;
    logic                           RST_I;
    logic                           i_stb;
    logic                           i_rs;
    logic [lcd_pkg::LCD_BYTE_W-1:0] i_lcd_data;
    logic                           o_busy;
    logic                           o_rs;
    logic [lcd_pkg::LCD_NYB_W-1:0]  o_lcd_data;
    logic                           o_e;

    int seed      = 29;
    int errors    = 0;
    int err_mark  = 0;
    int cycle_cnt = 0;
    int accepted  = 0;
    int pulses    = 0;
    int high_cnt  = 0;

    // expected {rs, nybble} in pin order, upper nybble of a byte first
    logic [lcd_pkg::LCD_NYB_W:0] exp_q[$];
    // rs of an accepted strobe waits here until the data byte is sampled
    logic pend    = 1'b0;
    logic pend_rs = 1'b0;
    logic e_prev  = 1'b0;

    hd44780_controller hd44780_controller_i (.*);

    initial begin
        CLK_I = 1'b0;
        forever #4 CLK_I = ~CLK_I;
    end

    always @(posedge CLK_I) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_equal(input string what, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %0d, expected %0d",
                     $time, what, got, expected);
        end
    endtask

    // **********************************************************************
    // model and monitor, on the falling edge where all DUT outputs are settled
    // **********************************************************************
    always @(negedge CLK_I) begin
        // the byte is the data seen on the first cycle with the strobe low again
        if (pend && !i_stb) begin
            exp_q.push_back({pend_rs, i_lcd_data[7:4]});
            exp_q.push_back({pend_rs, i_lcd_data[3:0]});
            pend = 1'b0;
        end
        // a strobe only counts while busy is low, rs comes from that same cycle
        if (!RST_I && i_stb && !o_busy) begin
            pend_rs = i_rs;
            pend    = 1'b1;
            accepted++;
        end
        // pins have to show the front nybble for the whole enable pulse
        if (o_e) begin
            high_cnt++;
            check_equal("rs and nybble while enable high", {o_rs, o_lcd_data}, exp_q[0]);
        end else if (e_prev) begin
            pulses++;
            check_equal("enable high cycles", high_cnt, lcd_pkg::T_PWEH_TICKS);
            check_equal("nybbles waiting at enable fall", exp_q.size() > 0, 1);
            check_equal("rs and nybble at enable fall", {o_rs, o_lcd_data}, exp_q.pop_front());
            high_cnt = 0;
        end
        e_prev = o_e;
    end

    // **********************************************************************
    // stimulus
    // **********************************************************************

    // returns on a falling edge with busy low
    task automatic wait_idle();
        @(negedge CLK_I);
        while (o_busy) @(negedge CLK_I);
    endtask

    // one random byte from strobe to the end of busy
    // optional noise on the strobe or on rs and data while the byte is in flight
    task automatic run_byte(input bit gap, input bit noisy_stb, input bit noisy_lines);
        int r;
        int a0;
        r  = $random(seed);
        a0 = accepted;
        wait_idle();
        repeat (gap ? r[5:4] : 0) @(posedge CLK_I);
        @(posedge CLK_I);
        i_stb      <= 1'b1;
        i_rs       <= r[8];
        i_lcd_data <= r[23:16];
        // strobe high for one to four cycles
        repeat (r[1:0]) @(posedge CLK_I);
        @(posedge CLK_I);
        i_stb <= 1'b0;
        // the first noise edge is the one that samples the byte
        // sixty cycles end well before the second nybble is through
        repeat (60) begin
            @(posedge CLK_I);
            r = $random(seed);
            i_stb <= noisy_stb & r[0];
            if (noisy_lines) begin
                i_rs       <= r[1];
                i_lcd_data <= r[15:8];
            end
        end
        @(posedge CLK_I);
        i_stb <= 1'b0;
        wait_idle();
        check_equal("strobes accepted for one byte", accepted - a0, 1);
        check_equal("nybbles still expected after busy", exp_q.size(), 0);
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        RST_I      = 1'b1;
        i_stb      = 1'b0;
        i_rs       = 1'b0;
        i_lcd_data = '0;
        repeat (8) @(posedge CLK_I);
        RST_I <= 1'b0;
        @(negedge CLK_I);
        check_equal("busy, enable, rs and data after reset", {o_busy, o_e, o_rs, o_lcd_data}, 0);
        finish_test("1 reset values");
        run_byte(1'b1, 1'b0, 1'b0);
        finish_test("2 one byte as two nybbles");
        run_byte(1'b1, 1'b0, 1'b0);
        finish_test("3 enable width and stable pins");
        run_byte(1'b1, 1'b1, 1'b0);
        finish_test("4 strobes while busy");
        run_byte(1'b1, 1'b0, 1'b1);
        finish_test("5 input changes after capture");
        repeat (40) begin
            run_byte(1'b0, 1'b0, 1'b0);
        end
        // no pulse may turn up once the last byte is through
        repeat (2 * lcd_pkg::NYB_XFER_TICKS) @(negedge CLK_I);
        check_equal("enable pulses over the run", pulses, 2 * accepted);
        check_equal("nybbles left over", exp_q.size(), 0);
        finish_test("6 random run of 40 bytes");
        $display("%0d bytes, %0d enable pulses, %0d errors", accepted, pulses, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
